//--- Makefile
# Verilator build of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_subsystem
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) design/rv_defines.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "=== PASS ===" $(LOG) || { echo "Simulation ended without result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/apb_sram.sv
//####################################################################
// APB slave SRAM, zero wait states
// Word array with byte write strobes and combinational read data
//####################################################################

`timescale 1ns/1ns
`include "rv_defines.svh"

module apb_sram (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  logic [`XLEN-1:0] paddr,   // Byte address
  input  logic [`XLEN-1:0] pwdata,
  input  logic [3:0]       pstrb,   // Byte lanes to write
  output logic [`XLEN-1:0] prdata,
  output logic             pready
);

  localparam int IDX_W = $clog2(`MEM_WORDS);

  logic [`XLEN-1:0] mem [`MEM_WORDS];  // Storage array
  logic [IDX_W-1:0] word_idx;          // Word select from byte address
  logic             ready_q;           // High from the first cycle out of reset

  assign word_idx = paddr[IDX_W+1:2];
  assign prdata   = mem[word_idx];
  assign pready   = ready_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;  // No wait states
    end
  end

  // Byte-lane write in the access phase
  always_ff @(posedge clk) begin
    if (psel && penable && pwrite) begin
      for (int i = 0; i < 4; i++) begin
        if (pstrb[i]) begin
          mem[word_idx][8*i +: 8] <= pwdata[8*i +: 8];
        end
      end
    end
  end

endmodule : apb_sram

//--- design/fetch_unit.sv
//####################################################################
// Instruction fetch unit
// PC register, one-entry output buffer, redirect and back-pressure
//####################################################################

`timescale 1ns/1ns
`include "rv_defines.svh"

module fetch_unit
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  fetch_en,     // Allow new fetches
  input  logic  redirect,     // Flush and restart at redirect_pc
  input  addr_t redirect_pc,
  input  logic  done,         // Fetch transfer finished
  input  data_t rdata,        // Fetched word
  input  logic  instr_ready,  // Consumer takes instr this cycle
  output logic  req,
  output addr_t addr,
  output logic  instr_valid,
  output data_t instr,
  output addr_t instr_pc
);

  addr_t pc_q;    // Next fetch address
  logic  drop_q;  // In-flight fetch is stale

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q        <= `RESET_PC;
      req         <= 1'b0;
      addr        <= '0;
      drop_q      <= 1'b0;
      instr_valid <= 1'b0;
      instr       <= '0;
      instr_pc    <= '0;
    end else if (redirect) begin
      pc_q        <= redirect_pc;
      instr_valid <= 1'b0;                 // Discard untaken output
      if (req && done) begin
        req    <= 1'b0;                    // Returning word thrown away
        drop_q <= 1'b0;
      end else if (req) begin
        drop_q <= 1'b1;                    // Let it finish, then drop
      end
    end else begin
      if (instr_valid && instr_ready) begin
        instr_valid <= 1'b0;               // Buffer taken
      end
      if (req && done) begin
        req    <= 1'b0;
        drop_q <= 1'b0;
        if (!drop_q) begin
          instr_valid <= 1'b1;
          instr       <= rdata;
          instr_pc    <= addr;
          pc_q        <= addr + addr_t'(4);  // Sequential PC
        end
      end else if (!req && fetch_en && !instr_valid) begin
        req  <= 1'b1;                      // Launch with buffer free
        addr <= pc_q;
      end
    end
  end

endmodule : fetch_unit

//--- design/lsu_subsystem_top.sv
//####################################################################
// Memory subsystem top
// MEM stage and fetch unit share one APB SRAM through the arbiter
//####################################################################

`timescale 1ns/1ns
`include "rv_defines.svh"

module lsu_subsystem_top
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ex_valid,
  input  addr_t     ex_mem_alu_res,
  input  data_t     ex_mem_store_data,
  input  reg_addr_t ex_mem_rd,
  input  lsu_op_e   lsu_op,
  output logic      stall,
  output logic      mem_wb_valid,
  output data_t     mem_wb_data,
  output data_t     mem_wb_alu_res,
  output reg_addr_t mem_wb_rd,
  input  logic      fetch_en,
  input  logic      redirect,
  input  addr_t     redirect_pc,
  input  logic      instr_ready,
  output logic      instr_valid,
  output data_t     instr,
  output addr_t     instr_pc
);

  logic  lsu_req;     // MEM stage request port
  addr_t lsu_addr;
  logic  lsu_write;
  data_t lsu_wdata;
  strb_t lsu_strb;
  logic  lsu_done;
  logic  if_req;      // Fetch request port, read only
  addr_t if_addr;
  logic  if_done;
  data_t mem_rdata;   // Shared read data to both masters
  logic  psel;        // APB bus
  logic  penable;
  logic  pwrite;
  addr_t paddr;
  data_t pwdata;
  strb_t pstrb;
  data_t prdata;
  logic  pready;

  mem_stage u_mem_stage (
    .clk, .rst_n, .ex_valid, .ex_mem_alu_res, .ex_mem_store_data, .ex_mem_rd, .lsu_op,
    .done(lsu_done), .rdata(mem_rdata), .stall, .req(lsu_req), .addr(lsu_addr),
    .write(lsu_write), .wdata(lsu_wdata), .strb(lsu_strb),
    .mem_wb_valid, .mem_wb_data, .mem_wb_alu_res, .mem_wb_rd
  );

  fetch_unit u_fetch_unit (
    .clk, .rst_n, .fetch_en, .redirect, .redirect_pc, .done(if_done), .rdata(mem_rdata),
    .instr_ready, .req(if_req), .addr(if_addr), .instr_valid, .instr, .instr_pc
  );

  mem_arbiter u_mem_arbiter (
    .clk, .rst_n, .lsu_req, .lsu_addr, .lsu_write, .lsu_wdata, .lsu_strb,
    .if_req, .if_addr, .prdata, .pready, .lsu_done, .if_done, .rdata(mem_rdata),
    .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb
  );

  apb_sram u_apb_sram (
    .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb, .prdata, .pready
  );

endmodule : lsu_subsystem_top

//--- design/mem_arbiter.sv
//####################################################################
// Two-port round-robin arbiter with APB master
// Serves the MEM stage and fetch ports over one APB bus
//####################################################################

`timescale 1ns/1ns
`include "rv_defines.svh"

module mem_arbiter
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  lsu_req,
  input  addr_t lsu_addr,
  input  logic  lsu_write,
  input  data_t lsu_wdata,
  input  strb_t lsu_strb,
  input  logic  if_req,
  input  addr_t if_addr,
  input  data_t prdata,
  input  logic  pready,
  output logic  lsu_done,
  output logic  if_done,
  output data_t rdata,      // Shared read data, valid with done
  output logic  psel,
  output logic  penable,
  output logic  pwrite,
  output addr_t paddr,
  output data_t pwdata,
  output strb_t pstrb
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } arb_state_e;

  arb_state_e state_q;
  logic       last_if_q;  // Fetch port won the last grant
  logic       gnt_if_q;   // Fetch port owns current transfer
  logic       lsu_elig;   // Request not already being completed
  logic       if_elig;
  logic       pick_if;

  assign lsu_elig = lsu_req && !lsu_done;
  assign if_elig  = if_req && !if_done;
  assign pick_if  = (lsu_elig && if_elig) ? !last_if_q : if_elig;  // Round robin

  assign psel    = (state_q != ST_IDLE);
  assign penable = (state_q == ST_ACCESS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= ST_IDLE;
      last_if_q <= 1'b0;
      gnt_if_q  <= 1'b0;
      lsu_done  <= 1'b0;
      if_done   <= 1'b0;
      rdata     <= '0;
      pwrite    <= 1'b0;
      paddr     <= '0;
      pwdata    <= '0;
      pstrb     <= '0;
    end else begin
      lsu_done <= 1'b0;  // Done is a pulse
      if_done  <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (lsu_elig || if_elig) begin
            state_q   <= ST_SETUP;
            gnt_if_q  <= pick_if;
            last_if_q <= pick_if;
            paddr     <= pick_if ? if_addr : lsu_addr;
            pwrite    <= pick_if ? 1'b0 : lsu_write;   // Fetch only reads
            pwdata    <= pick_if ? '0 : lsu_wdata;
            pstrb     <= pick_if ? '0 : lsu_strb;
          end
        end
        ST_SETUP: state_q <= ST_ACCESS;
        ST_ACCESS: begin
          if (pready) begin
            state_q  <= ST_IDLE;
            rdata    <= prdata;  // Capture read word
            lsu_done <= !gnt_if_q;
            if_done  <= gnt_if_q;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule : mem_arbiter

//--- design/mem_stage.sv
//####################################################################
// MEM pipeline stage
// Issues load/store requests, handles lanes and extension, registers WB
//####################################################################

`timescale 1ns/1ns
`include "rv_defines.svh"

module mem_stage
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ex_valid,           // EX holds a valid operation
  input  addr_t     ex_mem_alu_res,     // ALU result, address for memory ops
  input  data_t     ex_mem_store_data,  // Store data from EX
  input  reg_addr_t ex_mem_rd,          // Destination register
  input  lsu_op_e   lsu_op,             // Memory access operation
  input  logic      done,               // Transfer finished
  input  data_t     rdata,              // Read word from memory
  output logic      stall,              // Hold EX while access is pending
  output logic      req,
  output addr_t     addr,
  output logic      write,
  output data_t     wdata,
  output strb_t     strb,
  output logic      mem_wb_valid,
  output data_t     mem_wb_data,        // Load result, zero otherwise
  output data_t     mem_wb_alu_res,     // Carried from EX
  output reg_addr_t mem_wb_rd           // Carried from EX
);

  logic  is_mem;    // Operation touches memory
  logic  is_store;  // Operation writes memory
  strb_t st_strb;   // Lanes written by a store
  data_t st_data;   // Store data replicated across lanes
  data_t ld_shift;  // Read word with addressed lane moved to bit 0
  data_t ld_data;   // Aligned and extended load result
  logic  mem_fire;  // Memory op completes this cycle
  logic  alu_fire;  // Non-memory op passes this cycle

  // Operation decode
  always_comb begin
    is_mem   = 1'b1;
    is_store = 1'b0;
    st_strb  = '0;
    st_data  = '0;
    case (lsu_op)
      LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU: begin
        is_store = 1'b0;  // Reads need no strobes
      end
      LSU_SB: begin
        is_store = 1'b1;
        st_strb  = 4'b0001 << ex_mem_alu_res[1:0];  // One byte lane
        st_data  = {4{ex_mem_store_data[7:0]}};
      end
      LSU_SH: begin
        is_store = 1'b1;
        st_strb  = ex_mem_alu_res[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
        st_data  = {2{ex_mem_store_data[15:0]}};
      end
      LSU_SW: begin
        is_store = 1'b1;
        st_strb  = 4'b1111;
        st_data  = ex_mem_store_data;
      end
      default: begin
        is_mem = 1'b0;  // LSU_NONE and unused codes
      end
    endcase
  end

  assign req      = ex_valid && is_mem;  // Held by EX through the stall
  assign addr     = {ex_mem_alu_res[`XLEN-1:2], 2'b00};  // Word aligned
  assign write    = is_store;
  assign wdata    = st_data;
  assign strb     = st_strb;
  assign stall    = req && !done;  // Released in the done cycle
  assign mem_fire = req && done;
  assign alu_fire = ex_valid && !is_mem;

  // Lane select and extension of the read word
  always_comb begin
    ld_shift = rdata >> {ex_mem_alu_res[1:0], 3'b000};
    case (lsu_op[1:0])
      2'b00: ld_data = lsu_op[2] ? {{(`XLEN-8){1'b0}}, ld_shift[7:0]}
                                 : {{(`XLEN-8){ld_shift[7]}}, ld_shift[7:0]};
      2'b01: ld_data = lsu_op[2] ? {{(`XLEN-16){1'b0}}, ld_shift[15:0]}
                                 : {{(`XLEN-16){ld_shift[15]}}, ld_shift[15:0]};
      default: ld_data = rdata;  // Full word
    endcase
  end

  // Write-back register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_wb_valid   <= 1'b0;
      mem_wb_data    <= '0;
      mem_wb_alu_res <= '0;
      mem_wb_rd      <= '0;
    end else begin
      mem_wb_valid <= mem_fire || alu_fire;  // One-cycle pulse
      if (mem_fire || alu_fire) begin
        mem_wb_data    <= (mem_fire && !is_store) ? ld_data : '0;
        mem_wb_alu_res <= ex_mem_alu_res;
        mem_wb_rd      <= ex_mem_rd;
      end
    end
  end

endmodule : mem_stage

//--- design/rv_defines.svh
//####################################################################
// RV32 memory subsystem global macros
// Data width, register index width, SRAM depth and reset PC
//####################################################################

`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data and byte address width
`define XLEN 32

// Register file index width
`define REG_ADDR_W 5

// SRAM depth in 32-bit words
`define MEM_WORDS 256

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

//--- design/rv_pkg.sv
//####################################################################
// RV32 memory subsystem types
// Data, address, register index, strobe and LSU operation encodings
//####################################################################

`include "rv_defines.svh"

package rv_pkg;

  typedef logic [`XLEN-1:0]       data_t;      // One data word
  typedef logic [`XLEN-1:0]       addr_t;      // Byte address
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // Register index
  typedef logic [3:0]             strb_t;      // Byte write strobes

  // Bit 3 store, bit 2 unsigned, bits 1-0 size (00 byte, 01 half, 10 word)
  typedef enum logic [3:0] {
    LSU_LB   = 4'b0000,  // Load byte, sign extended
    LSU_LH   = 4'b0001,  // Load half, sign extended
    LSU_LW   = 4'b0010,  // Load word
    LSU_LBU  = 4'b0100,  // Load byte, zero extended
    LSU_LHU  = 4'b0101,  // Load half, zero extended
    LSU_SB   = 4'b1000,  // Store byte
    LSU_SH   = 4'b1001,  // Store half
    LSU_SW   = 4'b1010,  // Store word
    LSU_NONE = 4'b1111   // No memory access
  } lsu_op_e;

endpackage : rv_pkg

//--- sim.f
+incdir+design
design/rv_pkg.sv
design/mem_stage.sv
design/fetch_unit.sv
design/mem_arbiter.sv
design/apb_sram.sv
design/lsu_subsystem_top.sv
tb/tb_lsu_subsystem.sv

//--- tb/tb_lsu_subsystem.sv
//####################################################################
// Memory subsystem testbench
// Directed tests of loads, stores, fetch, redirect and sharing
//####################################################################

`timescale 1ns/1ns
`include "rv_defines.svh"

module tb_lsu_subsystem
  import rv_pkg::*;
;
  logic clk, rst_n, ex_valid, stall, mem_wb_valid;
  addr_t ex_mem_alu_res, redirect_pc, instr_pc;
  data_t ex_mem_store_data, mem_wb_data, mem_wb_alu_res, instr;
  reg_addr_t ex_mem_rd, mem_wb_rd;
  lsu_op_e lsu_op;
  logic fetch_en, redirect, instr_ready, instr_valid;
  data_t model [`MEM_WORDS];  // Expected SRAM contents
  int err_count = 0;
  int check_count = 0;

  lsu_subsystem_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  task automatic check_data(string name, data_t exp, data_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(string name, addr_t exp, addr_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_rd(string name, reg_addr_t exp, reg_addr_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic abort_on_timeout(string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("=== FAIL ===");
    $finish;
  endtask

  // Byte-lane merge of a store into the model
  task automatic update_model(lsu_op_e op, addr_t a, data_t d);
    int idx;
    idx = (a >> 2) % `MEM_WORDS;
    case (op)
      LSU_SB: model[idx][8*a[1:0] +: 8] = d[7:0];
      LSU_SH: model[idx][16*a[1] +: 16] = d[15:0];
      LSU_SW: model[idx] = d;
      default: ;
    endcase
  endtask

  // Expected load result with sign or zero extension
  function automatic data_t expect_load(lsu_op_e op, addr_t a);
    data_t w;
    logic [7:0] b;
    logic [15:0] h;
    w = model[(a >> 2) % `MEM_WORDS];
    b = w[8*a[1:0] +: 8];
    h = w[16*a[1] +: 16];
    case (op)
      LSU_LB:  return {{24{b[7]}}, b};
      LSU_LBU: return {24'h0, b};
      LSU_LH:  return {{16{h[15]}}, h};
      LSU_LHU: return {16'h0, h};
      default: return w;
    endcase
  endfunction

  // One EX operation; memory ops wait for write-back
  task automatic do_mem_op(lsu_op_e op, addr_t a, data_t d, reg_addr_t rd);
    int n;
    data_t exp;
    exp = op[3] ? '0 : expect_load(op, a);
    ex_valid = 1'b1;
    lsu_op = op;
    ex_mem_alu_res = a;
    ex_mem_store_data = d;
    ex_mem_rd = rd;
    #1 check_flag("stall", 1'b1, stall);  // Raised in the accept cycle
    n = 0;
    do begin
      @(posedge clk);
      #1 n++;
      if (n > 50) abort_on_timeout("mem_wb_valid");
    end while (!mem_wb_valid);
    check_data("mem_wb_data", exp, mem_wb_data);
    check_data("mem_wb_alu_res", a, mem_wb_alu_res);
    check_rd("mem_wb_rd", rd, mem_wb_rd);
    #1 ex_valid = 1'b0;
    lsu_op = LSU_NONE;
    if (op[3]) update_model(op, a, d);
  endtask

  // Waits for one instruction, holds it for a while, then takes it
  task automatic fetch_one(addr_t pc, int hold);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #1 n++;
      if (n > 50) abort_on_timeout("instr_valid");
    end while (!instr_valid);
    check_addr("instr_pc", pc, instr_pc);
    check_data("instr", model[(pc >> 2) % `MEM_WORDS], instr);
    repeat (hold) begin
      @(posedge clk);
      #1 check_flag("instr_valid", 1'b1, instr_valid);  // Back-pressure holds output
      check_addr("instr_pc", pc, instr_pc);
      check_data("instr", model[(pc >> 2) % `MEM_WORDS], instr);
    end
    #1 instr_ready = 1'b1;
    @(posedge clk);
    #2 instr_ready = 1'b0;
  endtask

  task automatic do_redirect(addr_t pc);
    redirect = 1'b1;
    redirect_pc = pc;
    @(posedge clk);
    #2 redirect = 1'b0;
  endtask

  task automatic report_test(string name, int err_start);
    $display("%s: %s", name, (err_count == err_start) ? "ok" : "errors");
  endtask

  task automatic test_reset_alu();
    int e0;
    e0 = err_count;
    check_flag("stall", 1'b0, stall);
    check_flag("mem_wb_valid", 1'b0, mem_wb_valid);
    check_flag("instr_valid", 1'b0, instr_valid);
    ex_valid = 1'b1;
    lsu_op = LSU_NONE;
    ex_mem_alu_res = 32'hCAFE_0123;
    ex_mem_rd = 5'd7;
    #1 check_flag("mem_wb_valid", 1'b0, mem_wb_valid);
    @(posedge clk);
    #1 check_flag("mem_wb_valid", 1'b1, mem_wb_valid);  // Exactly one cycle
    check_data("mem_wb_data", '0, mem_wb_data);
    check_data("mem_wb_alu_res", 32'hCAFE_0123, mem_wb_alu_res);
    check_rd("mem_wb_rd", 5'd7, mem_wb_rd);
    #1 ex_valid = 1'b0;
    report_test("test 1 reset and pass-through", e0);
  endtask

  task automatic test_word_random();
    int e0;
    addr_t a;
    data_t d;
    e0 = err_count;
    repeat (8) begin
      a = addr_t'(($urandom % `MEM_WORDS) << 2);
      d = $urandom;
      do_mem_op(LSU_SW, a, d, reg_addr_t'($urandom));
      do_mem_op(LSU_LW, a, '0, reg_addr_t'($urandom));
    end
    report_test("test 2 random word store and load", e0);
  endtask

  task automatic test_byte_half();
    int e0;
    e0 = err_count;
    do_mem_op(LSU_SW, 32'h200, 32'h8899_AABB, 5'd1);
    do_mem_op(LSU_SB, 32'h201, 32'h0000_00F3, 5'd2);  // Negative byte
    do_mem_op(LSU_SB, 32'h203, 32'h0000_0012, 5'd3);
    do_mem_op(LSU_SH, 32'h200, 32'h0000_7E55, 5'd4);
    for (int i = 0; i < 4; i++) begin
      do_mem_op(LSU_LB, 32'h200 + i, '0, 5'd5);
      do_mem_op(LSU_LBU, 32'h200 + i, '0, 5'd6);
    end
    do_mem_op(LSU_SH, 32'h202, 32'h0000_9C01, 5'd8);  // Negative upper half
    for (int i = 0; i < 4; i += 2) begin
      do_mem_op(LSU_LH, 32'h200 + i, '0, 5'd9);
      do_mem_op(LSU_LHU, 32'h200 + i, '0, 5'd10);
    end
    do_mem_op(LSU_LW, 32'h200, '0, 5'd11);
    report_test("test 3 byte and half lanes", e0);
  endtask

  task automatic test_fetch_seq();
    int e0;
    e0 = err_count;
    for (int i = 0; i <= 16; i++) begin
      do_mem_op(LSU_SW, addr_t'(i * 4), 32'h1000_0013 + i * 32'h0101, 5'd12);
    end
    fetch_en = 1'b1;
    for (int i = 0; i < 4; i++) begin
      fetch_one(`RESET_PC + i * 4, (i == 1) ? 4 : 0);
    end
    report_test("test 4 sequential fetch", e0);
  endtask

  task automatic test_redirect();
    int e0;
    e0 = err_count;
    @(posedge clk);  // Next sequential fetch now in flight
    #2 do_redirect(32'h40);
    fetch_one(32'h40, 0);
    report_test("test 5 redirect", e0);
  endtask

  task automatic test_shared();
    int e0;
    int n;
    e0 = err_count;
    n = 0;
    while (!instr_valid) begin  // Leave the next word untaken
      @(posedge clk);
      #1 n++;
      if (n > 50) abort_on_timeout("instr_valid");
    end
    #1 do_redirect(32'h0);  // Pending output is discarded
    fork
      begin
        @(posedge clk);  // Load meets the first fetch request
        #2 do_mem_op(LSU_LW, 32'h200, '0, 5'd13);
      end
      for (int i = 0; i < 4; i++) fetch_one(addr_t'(i * 4), 0);
    join
    fetch_en = 1'b0;
    report_test("test 6 load during fetch", e0);
  endtask

  initial begin
    void'($urandom(32'h566));
    rst_n = 1'b0;
    ex_valid = 1'b0;
    ex_mem_alu_res = '0;
    ex_mem_store_data = '0;
    ex_mem_rd = '0;
    lsu_op = LSU_NONE;
    fetch_en = 1'b0;
    redirect = 1'b0;
    redirect_pc = '0;
    instr_ready = 1'b0;
    repeat (2) @(posedge clk);
    #2 rst_n = 1'b1;
    @(posedge clk);
    #2;
    test_reset_alu();
    test_word_random();
    test_byte_half();
    test_fetch_seq();
    test_redirect();
    test_shared();
    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) $display("=== PASS ===");
    else $display("=== FAIL ===");
    $finish;
  end

endmodule : tb_lsu_subsystem
